// ==== rtl/aluCluster_params.svh ====
`ifndef ALUCLUSTER_PARAMS_SVH
`define ALUCLUSTER_PARAMS_SVH

// --------------------
// Cluster size
// --------------------
`define ALU_NUM_LANES   4                           // 1 to 8 lanes
`define ALU_XLEN        32
`define ALU_ADR_W       6                           // Wishbone word address

// --------------------
// Register map
// --------------------
`define ALU_REG_RS1     2'd0
`define ALU_REG_RS2     2'd1
`define ALU_REG_INSTR   2'd2                        // Write launches the lane
`define ALU_REG_RESULT  2'd3
`define ALU_ADR_STATUS  (4 * `ALU_NUM_LANES)        // First word after the lanes
`define ALU_ADR_COUNT   (`ALU_ADR_STATUS + 1)

`endif

// ==== rtl/aluClusterPkg.sv ====
package aluClusterPkg;

`include "aluCluster_params.svh"

    typedef logic [`ALU_XLEN-1:0] aluWordT;

    // RV32I major opcodes handled by a lane
    typedef enum logic [6:0] {
        opcLoad   = 7'b0000011,
        opcOpImm  = 7'b0010011,
        opcStore  = 7'b0100011,
        opcOp     = 7'b0110011,
        opcBranch = 7'b1100011
    } rvOpcodeE;

    // Operation class, same coding as the classic ALUOp
    typedef enum logic [1:0] {
        addrCalc = 2'b00,   // Load and store
        branch   = 2'b01,
        regReg   = 2'b10,
        regImm   = 2'b11
    } aluOpE;

    typedef enum logic [3:0] {
        none,
        add,
        sub,
        subUnsigned,
        andOp,
        orOp,
        xorOp,
        shiftL,
        shiftR,
        shiftRArith,
        ltSigned,
        ltUnsigned
    } aluCtrlE;

    typedef enum logic [1:0] {rdNone, rdResult, rdStatus, rdCount} rdSelE;

endpackage

// ==== rtl/aluDispatch.sv ====
`include "aluCluster_params.svh"

module aluDispatch import aluClusterPkg::*; (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          cyc,
    input  logic                          stb,
    input  logic                          we,
    input  logic [`ALU_ADR_W-1:0]         adr,
    input  aluWordT                       datW,
    output logic                          ack,
    output logic [`ALU_NUM_LANES-1:0]     laneWrEn,
    output logic [1:0]                    wrReg,
    output aluWordT                       wrData,
    output logic                          countClr,
    output rdSelE                         rdSel,
    output logic [`ALU_ADR_W-3:0]         rdLane
);

    localparam int AdrStatus = `ALU_ADR_STATUS;
    localparam int AdrCount  = `ALU_ADR_COUNT;

    logic                  req;
    logic                  laneHit;
    logic [`ALU_ADR_W-3:0] laneIdx;
    logic [1:0]            regOff;

    // --------------------
    // Address decode
    // --------------------
    assign req     = cyc && stb && !ack;            // New access, not yet acked
    assign laneIdx = adr[`ALU_ADR_W-1:2];
    assign regOff  = adr[1:0];
    assign laneHit = int'(adr) < AdrStatus;

    // Single cycle ack
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            ack <= 1'b0;
        end else begin
            ack <= req;
        end
    end

    // --------------------
    // Write strobes
    // --------------------
    always_comb begin
        laneWrEn = '0;
        for (int i = 0; i < `ALU_NUM_LANES; i++) begin
            if (req && we && laneHit && int'(laneIdx) == i) begin
                laneWrEn[i] = 1'b1;
            end
        end
    end

    assign wrReg    = regOff;
    assign wrData   = datW;                         // Broadcast to every lane
    assign countClr = req && we && int'(adr) == AdrCount;

    // --------------------
    // Read select
    // --------------------
    // Collector registers datR on the same edge as ack
    always_comb begin
        rdSel = rdNone;
        if (req && !we) begin
            if (laneHit && regOff == `ALU_REG_RESULT) begin
                rdSel = rdResult;
            end else if (int'(adr) == AdrStatus) begin
                rdSel = rdStatus;
            end else if (int'(adr) == AdrCount) begin
                rdSel = rdCount;
            end
        end
    end

    assign rdLane = laneIdx;

    // Bus handshake checks
    assert property (@(posedge clk) disable iff (!arstN)
        ack |=> !ack);

    assert property (@(posedge clk) disable iff (!arstN)
        ack |-> $past(cyc && stb));

endmodule

// ==== rtl/aluLane.sv ====
`include "aluCluster_params.svh"

module aluLane import aluClusterPkg::*; (
    input  logic        clk,
    input  logic        arstN,
    input  logic        wrEn,
    input  logic [1:0]  wrReg,
    input  aluWordT     wrData,
    output aluWordT     result,
    output logic        taken,
    output logic        done
);

    localparam logic [6:0] F7Base = 7'b0000000;
    localparam logic [6:0] F7Alt  = 7'b0100000;     // SUB and SRA

    aluWordT    rs1Q;
    aluWordT    rs2Q;
    aluWordT    instrQ;
    logic       launchQ;
    rvOpcodeE   opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    aluOpE      aluOp;
    logic       aluSrc;
    logic       opValid;
    aluWordT    immI;
    aluWordT    immS;
    aluWordT    imm;
    aluCtrlE    aluCtrl;
    aluWordT    operand2;
    aluWordT    aluOut;
    logic       takenNext;

    // Operand and instruction holding registers
    always_ff @(posedge clk) begin
        if (wrEn && wrReg == `ALU_REG_RS1) rs1Q <= wrData;
        if (wrEn && wrReg == `ALU_REG_RS2) rs2Q <= wrData;
        if (wrEn && wrReg == `ALU_REG_INSTR) instrQ <= wrData;
    end

    // --------------------
    // Instruction decode
    // --------------------
    assign opcode = rvOpcodeE'(instrQ[6:0]);
    assign funct3 = instrQ[14:12];
    assign funct7 = instrQ[31:25];
    assign immI   = {{20{instrQ[31]}}, instrQ[31:20]};
    assign immS   = {{20{instrQ[31]}}, instrQ[31:25], instrQ[11:7]};

    always_comb begin
        aluOp   = addrCalc;
        aluSrc  = 1'b0;
        opValid = 1'b1;
        imm     = immI;
        case (opcode)
            opcOp:     aluOp = regReg;
            opcBranch: aluOp = branch;
            opcOpImm: begin
                aluOp  = regImm;
                aluSrc = 1'b1;
            end
            opcLoad:   aluSrc = 1'b1;
            opcStore: begin
                aluSrc = 1'b1;
                imm    = immS;
            end
            default:   opValid = 1'b0;
        endcase
    end

    // ALU control from the operation class and funct fields
    always_comb begin
        aluCtrl = none;
        if (opValid) begin
            case (aluOp)
                addrCalc: aluCtrl = add;
                branch: begin
                    case (funct3)
                        3'b000, 3'b001, 3'b100, 3'b101: aluCtrl = sub;
                        3'b110, 3'b111:                 aluCtrl = subUnsigned;
                        default:                        aluCtrl = none;
                    endcase
                end
                regReg: begin
                    case ({funct7, funct3})
                        {F7Base, 3'b000}: aluCtrl = add;
                        {F7Alt,  3'b000}: aluCtrl = sub;
                        {F7Base, 3'b001}: aluCtrl = shiftL;
                        {F7Base, 3'b010}: aluCtrl = ltSigned;
                        {F7Base, 3'b011}: aluCtrl = ltUnsigned;
                        {F7Base, 3'b100}: aluCtrl = xorOp;
                        {F7Base, 3'b101}: aluCtrl = shiftR;
                        {F7Alt,  3'b101}: aluCtrl = shiftRArith;
                        {F7Base, 3'b110}: aluCtrl = orOp;
                        {F7Base, 3'b111}: aluCtrl = andOp;
                        default:          aluCtrl = none;
                    endcase
                end
                regImm: begin
                    case (funct3)
                        3'b000: aluCtrl = add;
                        3'b010: aluCtrl = ltSigned;
                        3'b011: aluCtrl = ltUnsigned;
                        3'b100: aluCtrl = xorOp;
                        3'b110: aluCtrl = orOp;
                        3'b111: aluCtrl = andOp;
                        3'b001: aluCtrl = (funct7 == F7Base) ? shiftL : none;
                        3'b101: begin
                            if (funct7 == F7Base) aluCtrl = shiftR;
                            else if (funct7 == F7Alt) aluCtrl = shiftRArith;
                        end
                        default: aluCtrl = none;
                    endcase
                end
                default: aluCtrl = none;
            endcase
        end
    end

    // --------------------
    // Datapath
    // --------------------
    assign operand2 = aluSrc ? imm : rs2Q;

    always_comb begin
        case (aluCtrl)
            add:         aluOut = rs1Q + operand2;
            sub, subUnsigned: aluOut = rs1Q - operand2;   // Also the branch difference
            andOp:       aluOut = rs1Q & operand2;
            orOp:        aluOut = rs1Q | operand2;
            xorOp:       aluOut = rs1Q ^ operand2;
            shiftL:      aluOut = rs1Q << operand2[4:0];
            shiftR:      aluOut = rs1Q >> operand2[4:0];
            shiftRArith: aluOut = $signed(rs1Q) >>> operand2[4:0];
            ltSigned:    aluOut = {31'b0, $signed(rs1Q) < $signed(operand2)};
            ltUnsigned:  aluOut = {31'b0, rs1Q < operand2};
            default:     aluOut = '0;
        endcase
    end

    // Branch decision compares the operands directly
    always_comb begin
        takenNext = 1'b0;
        if (opValid && aluOp == branch) begin
            case (funct3)
                3'b000:  takenNext = rs1Q == rs2Q;
                3'b001:  takenNext = rs1Q != rs2Q;
                3'b100:  takenNext = $signed(rs1Q) < $signed(rs2Q);
                3'b101:  takenNext = $signed(rs1Q) >= $signed(rs2Q);
                3'b110:  takenNext = rs1Q < rs2Q;
                3'b111:  takenNext = rs1Q >= rs2Q;
                default: takenNext = 1'b0;
            endcase
        end
    end

    // --------------------
    // Launch and done
    // --------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            launchQ <= 1'b0;
            done    <= 1'b0;
            taken   <= 1'b0;
            result  <= '0;
        end else if (wrEn && wrReg == `ALU_REG_INSTR) begin
            launchQ <= 1'b1;
            done    <= 1'b0;                        // Relaunch hides the old result
        end else if (launchQ) begin
            launchQ <= 1'b0;
            result  <= aluOut;
            taken   <= takenNext;
            done    <= 1'b1;
        end
    end

    // Done only ever follows an instruction write
    assert property (@(posedge clk) disable iff (!arstN)
        $rose(done) |-> $past(wrEn && wrReg == `ALU_REG_INSTR, 2));

endmodule

// ==== rtl/aluCollect.sv ====
`include "aluCluster_params.svh"

module aluCollect import aluClusterPkg::*; (
    input  logic                                  clk,
    input  logic                                  arstN,
    input  aluWordT [`ALU_NUM_LANES-1:0]          laneResult,
    input  logic [`ALU_NUM_LANES-1:0]             laneTaken,
    input  logic [`ALU_NUM_LANES-1:0]             laneDone,
    input  logic                                  countClr,
    input  rdSelE                                 rdSel,
    input  logic [`ALU_ADR_W-3:0]                 rdLane,
    output aluWordT                               datR
);

    logic [`ALU_NUM_LANES-1:0] doneQ;
    logic [`ALU_NUM_LANES-1:0] doneRise;
    aluWordT                   count;
    aluWordT                   status;

    // Number of lanes finishing this cycle
    function automatic aluWordT popCount(input logic [`ALU_NUM_LANES-1:0] bits);
        aluWordT n;
        n = '0;
        for (int i = 0; i < `ALU_NUM_LANES; i++) begin
            n = n + aluWordT'(bits[i]);
        end
        return n;
    endfunction

    // --------------------
    // Completion counter
    // --------------------
    assign doneRise = laneDone & ~doneQ;

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            doneQ <= '0;
            count <= '0;
        end else begin
            doneQ <= laneDone;
            if (countClr) begin
                count <= '0;                        // Clear wins over new completions
            end else begin
                count <= count + popCount(doneRise);
            end
        end
    end

    // Done in the low byte, taken from bit 8
    always_comb begin
        status = '0;
        status[`ALU_NUM_LANES-1:0] = laneDone;
        status[8 +: `ALU_NUM_LANES] = laneTaken;
    end

    // --------------------
    // Read data
    // --------------------
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            datR <= '0;
        end else begin
            case (rdSel)
                rdResult: datR <= laneResult[rdLane];   // Lane index checked by dispatch
                rdStatus: datR <= status;
                rdCount:  datR <= count;
                default:  datR <= '0;
            endcase
        end
    end

endmodule

// ==== rtl/aluClusterTop.sv ====
`include "aluCluster_params.svh"

module aluClusterTop import aluClusterPkg::*; (
    input  logic                  clk,
    input  logic                  arstN,
    input  logic                  cyc,
    input  logic                  stb,
    input  logic                  we,
    input  logic [`ALU_ADR_W-1:0] adr,
    input  aluWordT               datW,
    output aluWordT               datR,
    output logic                  ack
);

    logic [`ALU_NUM_LANES-1:0]    laneWrEn;
    logic [1:0]                   wrReg;
    aluWordT                      wrData;
    logic                         countClr;
    rdSelE                        rdSel;
    logic [`ALU_ADR_W-3:0]        rdLane;
    aluWordT [`ALU_NUM_LANES-1:0] laneResult;
    logic [`ALU_NUM_LANES-1:0]    laneTaken;
    logic [`ALU_NUM_LANES-1:0]    laneDone;

    // --------------------
    // Bus front end
    // --------------------
    aluDispatch dispatch_i (
        .clk      (clk),
        .arstN    (arstN),
        .cyc      (cyc),
        .stb      (stb),
        .we       (we),
        .adr      (adr),
        .datW     (datW),
        .ack      (ack),
        .laneWrEn (laneWrEn),
        .wrReg    (wrReg),
        .wrData   (wrData),
        .countClr (countClr),
        .rdSel    (rdSel),
        .rdLane   (rdLane)
    );

    // One execute lane per slot
    for (genvar k = 0; k < `ALU_NUM_LANES; k++) begin : gLane
        aluLane lane_i (
            .clk    (clk),
            .arstN  (arstN),
            .wrEn   (laneWrEn[k]),
            .wrReg  (wrReg),
            .wrData (wrData),
            .result (laneResult[k]),
            .taken  (laneTaken[k]),
            .done   (laneDone[k])
        );
    end

    aluCollect collect_i (
        .clk        (clk),
        .arstN      (arstN),
        .laneResult (laneResult),
        .laneTaken  (laneTaken),
        .laneDone   (laneDone),
        .countClr   (countClr),
        .rdSel      (rdSel),
        .rdLane     (rdLane),
        .datR       (datR)
    );

endmodule

// ==== verification/aluClusterTb.sv ====
`include "aluCluster_params.svh"

module aluClusterTb import aluClusterPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NumLanes = `ALU_NUM_LANES;
    localparam int AdrW     = `ALU_ADR_W;
    localparam int LaneBits = (NumLanes > 1) ? $clog2(NumLanes) : 1;

    typedef logic [AdrW-1:0] adrT;

    logic    clk;
    logic    arstN;
    logic    cyc;
    logic    stb;
    logic    we;
    adrT     adr;
    aluWordT datW;
    aluWordT datR;
    logic    ack;

    aluWordT vecInstr[$];
    aluWordT vecRs1[$];
    aluWordT vecRs2[$];
    aluWordT vecResult[$];
    logic    vecTaken[$];

    logic [31:0] lfsr = 32'hce55_093b;
    int cycles = 0;
    int cycleLimit = 500;                           // Raised once the vectors are known
    int launches = 0;

    aluClusterTop dut_i (
        .clk   (clk),
        .arstN (arstN),
        .cyc   (cyc),
        .stb   (stb),
        .we    (we),
        .adr   (adr),
        .datW  (datW),
        .datR  (datR),
        .ack   (ack)
    );

    always #4 clk = ~clk;

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycles >= cycleLimit) abortRun("timeout: DUT did not finish");
    end

    // --------------------
    // Compare tasks
    // --------------------
    task automatic checkWord(input string name, input aluWordT expected, input aluWordT actual);
        if (actual !== expected) begin
            abortRun($sformatf("Fail %s: expected %h, actual %h", name, expected, actual));
        end
    endtask

    task automatic checkFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            abortRun($sformatf("Fail %s: expected %b, actual %b", name, expected, actual));
        end
    endtask

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrNext(input logic [31:0] s);
        logic fb;
        fb = s[31] ^ s[21] ^ s[1] ^ s[0];
        return {s[30:0], fb};
    endfunction

    task automatic pickLane(output int lane);
        int v;
        v = 0;
        for (int b = 0; b < LaneBits; b++) begin
            lfsr = lfsrNext(lfsr);
            v = (v << 1) | int'(lfsr[0]);
        end
        lane = v % NumLanes;
    endtask

    function automatic adrT laneAdr(input int lane, input int off);
        return adrT'(lane * 4 + off);
    endfunction

    // --------------------
    // Wishbone master
    // --------------------
    task automatic wbWrite(input adrT a, input aluWordT d);
        @(negedge clk);
        cyc  = 1'b1;
        stb  = 1'b1;
        we   = 1'b1;
        adr  = a;
        datW = d;
        do @(negedge clk); while (ack !== 1'b1);
        cyc = 1'b0;
        stb = 1'b0;
        we  = 1'b0;
    endtask

    task automatic wbRead(input adrT a, output aluWordT d);
        @(negedge clk);
        cyc = 1'b1;
        stb = 1'b1;
        we  = 1'b0;
        adr = a;
        do @(negedge clk); while (ack !== 1'b1);
        d   = datR;                                 // Registered together with ack
        cyc = 1'b0;
        stb = 1'b0;
    endtask

    task automatic launchVector(input int lane, input int idx);
        wbWrite(laneAdr(lane, `ALU_REG_RS1), vecRs1[idx]);
        wbWrite(laneAdr(lane, `ALU_REG_RS2), vecRs2[idx]);
        wbWrite(laneAdr(lane, `ALU_REG_INSTR), vecInstr[idx]);
        launches++;
    endtask

    task automatic waitLaneDone(input int lane, output aluWordT st);
        st = '0;
        while (st[lane] !== 1'b1) wbRead(adrT'(`ALU_ADR_STATUS), st);
    endtask

    task automatic loadVectors();
        int fd;
        int got;
        string line;
        aluWordT instr;
        aluWordT rs1;
        aluWordT rs2;
        aluWordT res;
        aluWordT tk;
        fd = $fopen("verification/aluTestdata.txt", "r");
        if (fd == 0) begin
            abortRun("cannot open verification/aluTestdata.txt");
        end else begin
            while (!$feof(fd)) begin
                line = "";
                got = $fgets(line, fd);
                if (got > 0 && line.len() > 1 && line.substr(0, 1) != "//") begin
                    got = $sscanf(line, "%h %h %h %h %h", instr, rs1, rs2, res, tk);
                    if (got == 5) begin
                        vecInstr.push_back(instr);
                        vecRs1.push_back(rs1);
                        vecRs2.push_back(rs2);
                        vecResult.push_back(res);
                        vecTaken.push_back(tk[0]);
                    end
                end
            end
            $fclose(fd);
            if (vecInstr.size() == 0) abortRun("no test vectors in the data file");
        end
    endtask

    // --------------------
    // Test sequence
    // --------------------
    initial begin
        aluWordT st;
        aluWordT rd;
        int lane;
        int idx;
        clk   = 1'b0;
        arstN = 1'b0;
        cyc   = 1'b0;
        stb   = 1'b0;
        we    = 1'b0;
        adr   = '0;
        datW  = '0;
        loadVectors();
        cycleLimit = 200 * vecInstr.size() + 500;
        repeat (2) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;

        wbRead(adrT'(`ALU_ADR_STATUS), st);
        checkWord("status after reset", '0, st);
        wbRead(adrT'(`ALU_ADR_COUNT), rd);
        checkWord("count after reset", '0, rd);

        // Every vector on a random lane, result and taken flag
        for (int i = 0; i < vecInstr.size(); i++) begin
            pickLane(lane);
            launchVector(lane, i);
            waitLaneDone(lane, st);
            checkFlag($sformatf("vector %0d taken", i), vecTaken[i], st[8 + lane]);
            wbRead(laneAdr(lane, `ALU_REG_RESULT), rd);
            checkWord($sformatf("vector %0d result", i), vecResult[i], rd);
        end

        // All lanes in flight before any read
        for (int k = 0; k < NumLanes; k++) launchVector(k, (k * 5) % vecInstr.size());
        st = '0;
        while (st[NumLanes-1:0] !== {NumLanes{1'b1}}) wbRead(adrT'(`ALU_ADR_STATUS), st);
        for (int k = 0; k < NumLanes; k++) begin
            idx = (k * 5) % vecInstr.size();
            checkFlag($sformatf("lane %0d taken", k), vecTaken[idx], st[8 + k]);
            wbRead(laneAdr(k, `ALU_REG_RESULT), rd);
            checkWord($sformatf("lane %0d result", k), vecResult[idx], rd);
        end

        // Relaunch, done must drop right after the instruction ack
        pickLane(lane);
        launchVector(lane, 1);
        checkFlag("relaunch clears done", 1'b0, dut_i.laneDone[lane]);
        waitLaneDone(lane, st);
        wbRead(laneAdr(lane, `ALU_REG_RESULT), rd);
        checkWord("relaunch result", vecResult[1], rd);

        // Completion counter
        wbRead(adrT'(`ALU_ADR_COUNT), rd);
        checkWord("count of launches", aluWordT'(launches), rd);
        wbWrite(adrT'(`ALU_ADR_COUNT), 32'hffff_ffff);
        wbRead(adrT'(`ALU_ADR_COUNT), rd);
        checkWord("count after clear", '0, rd);
        for (int n = 1; n <= 2; n++) begin
            pickLane(lane);
            launchVector(lane, n + 2);
            waitLaneDone(lane, st);
            wbRead(laneAdr(lane, `ALU_REG_RESULT), rd);
            checkWord($sformatf("recount vector %0d result", n + 2), vecResult[n + 2], rd);
            wbRead(adrT'(`ALU_ADR_COUNT), rd);
            checkWord($sformatf("count after %0d new launches", n), aluWordT'(n), rd);
        end

        // Unmapped space, writes ignored and reads give zero
        wbWrite(adrT'(`ALU_ADR_COUNT + 2), 32'hdead_beef);
        wbRead(adrT'(`ALU_ADR_COUNT + 2), rd);
        checkWord("unmapped read", '0, rd);
        wbRead('1, rd);
        checkWord("top address read", '0, rd);
        wbRead(adrT'(`ALU_ADR_COUNT), rd);
        checkWord("count after unmapped write", aluWordT'(2), rd);

        $display("PASS: all tests");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/aluClusterPkg.sv
rtl/aluDispatch.sv
rtl/aluLane.sv
rtl/aluCollect.sv
rtl/aluClusterTop.sv
verification/aluClusterTb.sv

// ==== Makefile ====
SIM  := obj_dir/ValuClusterTb
SRCS := $(filter-out +incdir+%,$(shell cat sources.f)) rtl/aluCluster_params.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): sources.f $(SRCS)
	verilator --binary --assert -Wno-fatal --top-module aluClusterTb -f sources.f

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^PASS: all tests" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== verification/aluTestdata.txt ====
// instr    rs1      rs2      result   taken   (all hex)
// R-type, I-type, load/store address, branch, unsupported encodings
003100B3 00000005 00000007 0000000C 0
403100B3 00000003 00000005 FFFFFFFE 0
003110B3 00000001 00000024 00000010 0
003120B3 FFFFFFFF 00000001 00000001 0
003130B3 FFFFFFFF 00000001 00000000 0
003140B3 F0F0F0F0 FF00FF00 0FF00FF0 0
003150B3 80000000 00000004 08000000 0
403150B3 80000000 00000004 F8000000 0
003160B3 12340000 00005678 12345678 0
003170B3 FFFF0000 0F0F0F0F 0F0F0000 0
023100B3 00000005 00000007 00000000 0
FFF10093 00000010 12345678 0000000F 0
7FF10093 00000001 00000000 00000800 0
FFB12093 FFFFFFF0 00000000 00000001 0
FFF13093 00000005 00000000 00000001 0
0FF14093 0000FFFF 00000000 0000FF00 0
0F016093 00000F00 00000000 00000FF0 0
00F17093 12345678 00000000 00000008 0
00811093 000000AB 00000000 0000AB00 0
00415093 F0000000 00000000 0F000000 0
40415093 F0000000 00000000 FF000000 0
40411093 F0000000 00000000 00000000 0
01012083 00001000 00000000 00001010 0
FFC12083 00002000 00000000 00001FFC 0
02312223 00000100 55555555 00000124 0
FE312C23 00000100 55555555 000000F8 0
00310063 00000007 00000007 00000000 1
00311063 00000007 00000007 00000000 0
00314063 FFFFFFFF 00000001 FFFFFFFE 1
00315063 FFFFFFFF 00000001 FFFFFFFE 0
00316063 FFFFFFFF 00000001 FFFFFFFE 0
00317063 FFFFFFFF 00000001 FFFFFFFE 1
00316063 00000001 80000000 80000001 1
00317063 00000001 80000000 80000001 0
00312063 00000001 00000002 00000000 0
123450B7 00000001 00000002 00000000 0
